// File: include/ag_params.svh
`ifndef AG_PARAMS_SVH
`define AG_PARAMS_SVH

// Downstream stages with write scoreboards (AG2, ME, ME2, EX)
`define AG_NUM_DS_STAGES 4

// Interrupt descriptor entry addresses
`define AG_VEC_NMI        32'h0000_0010
`define AG_VEC_PAGE_FAULT 32'h0000_0070
`define AG_VEC_GEN_PROT   32'h0000_0068

// Architectural register counts
`define AG_NUM_GPR 8
`define AG_NUM_SEG 8
`define AG_NUM_MM  8

// Segment id of CS and the dword size code
`define AG_SEG_CS     3'd1
`define AG_SIZE_DWORD 2'd2

`endif

// File: hw/ag_pkg.sv
`include "ag_params.svh"

package ag_pkg;

   // One GPR split into its three write lanes
   typedef struct packed {
      logic upper;
      logic hi_byte;
      logic lo_byte;
   } gpr_lane_t;

   // GPR scoreboard, read flat for overlap tests or per register for encoding
   typedef union packed {
      logic [3*`AG_NUM_GPR-1:0]    flat;
      gpr_lane_t [`AG_NUM_GPR-1:0] grp;
   } gpr_sb_u;

   typedef struct packed {
      logic                  valid;
      gpr_sb_u               gpr;
      logic [`AG_NUM_SEG-1:0] seg;
      logic [`AG_NUM_MM-1:0]  mm;
   } sb_t;

   typedef struct packed {
      logic [31:0] eip;
      logic [15:0] cs;
      logic [47:0] far_off;
      logic [31:0] disp32;
      logic [31:0] imm32;
      logic [2:0]  sr1, sr2, sr3, sib_i, seg1, seg2, dr1;
      logic [1:0]  sr1_size, sr2_size, dr1_size, mem_size;
      logic        sr1_needed, sr2_needed, seg1_needed, seg2_needed;
      logic        sib_en, disp_en, base_en, use_cs_seg;
      logic [1:0]  sib_scale;
      logic        jmp_rel, far_eip, far_cs;
      logic [1:0]  mux_a;
      logic        b_imm, sp_push, cmpxchg, ld_gpr1, ld_seg;
      logic        nmi, pf, gp;
      logic [31:0] sr1_data, sr2_data, sr3_data, sib_i_data;
      logic [15:0] seg1_data, seg2_data;
   } uop_t;

   typedef struct packed {
      gpr_sb_u                gpr;
      logic [`AG_NUM_SEG-1:0] seg;
   } src_req_t;

   typedef struct packed {
      logic [31:0] neip;
      logic [15:0] ncs;
      logic [31:0] a_val, b_val;
      logic [31:0] base_disp, sib_si, sib_seg;
      logic [31:0] sp_xchg;
      logic [31:0] int_addr;
      sb_t         wr_sb;
   } ag_result_t;

   // Lanes touched by one register access of the given size
   function automatic gpr_sb_u gpr_lanes(input logic [2:0] id, input logic [1:0] size);
      gpr_sb_u m;
      m.flat = '0;
      case (size)
         2'd0: begin
            // Ids 4 to 7 name AH, CH, DH, BH
            if (id[2]) m.grp[{1'b0, id[1:0]}].hi_byte = 1'b1;
            else m.grp[{1'b0, id[1:0]}].lo_byte = 1'b1;
         end
         2'd1: begin
            m.grp[id].lo_byte = 1'b1;
            m.grp[id].hi_byte = 1'b1;
         end
         default: m.grp[id] = 3'b111;
      endcase
      return m;
   endfunction

endpackage

// File: hw/hazard_compare.sv
`timescale 1ns/1ps

module hazard_compare
   import ag_pkg::*;
(
   input  src_req_t src,
   input  sb_t      stage_sb,
   output logic     hit
);

   logic gpr_overlap;
   logic seg_overlap;

   // Lane-wise overlap
   // AL and AH sit in separate lanes so they never collide
   assign gpr_overlap = |(src.gpr.flat & stage_sb.gpr.flat);

   assign seg_overlap = |(src.seg & stage_sb.seg);

   // An empty pipeline slot carries stale masks
   assign hit = stage_sb.valid && (gpr_overlap || seg_overlap);

endmodule

// File: hw/ag_operand_latch.sv
`timescale 1ns/1ps
`include "ag_params.svh"

module ag_operand_latch
   import ag_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_req,
   input  uop_t     in_uop,
   output logic     in_ack,
   input  logic     release_uop,
   output logic     full,
   output uop_t     held_uop,
   output src_req_t src_req
);

   logic    take;
   gpr_sb_u sr1_lanes;
   gpr_sb_u sr2_lanes;
   gpr_sb_u sr3_lanes;
   gpr_sb_u sib_lanes;

   // New request only after the previous handshake has fully closed
   assign take = in_req && !in_ack && !full;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full   <= 1'b0;
         in_ack <= 1'b0;
      end else begin
         if (take) begin
            full   <= 1'b1;
            in_ack <= 1'b1;
         end else begin
            if (release_uop) begin
               full <= 1'b0;
            end
            if (in_ack && !in_req) begin
               in_ack <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         held_uop <= in_uop;
      end
   end

   assign sr1_lanes = gpr_lanes(held_uop.sr1, held_uop.sr1_size);
   assign sr2_lanes = gpr_lanes(held_uop.sr2, held_uop.sr2_size);
   // CMPXCHG compares against the accumulator at the SR2 operand size
   assign sr3_lanes = gpr_lanes(held_uop.sr3, held_uop.sr2_size);
   assign sib_lanes = gpr_lanes(held_uop.sib_i, `AG_SIZE_DWORD);

   // Source read masks, empty while nothing is held
   always_comb begin
      src_req = '0;
      if (full) begin
         if (held_uop.sr1_needed || held_uop.base_en) begin
            src_req.gpr.flat = src_req.gpr.flat | sr1_lanes.flat;
         end
         if (held_uop.sr2_needed) begin
            src_req.gpr.flat = src_req.gpr.flat | sr2_lanes.flat;
         end
         if (held_uop.cmpxchg) begin
            src_req.gpr.flat = src_req.gpr.flat | sr3_lanes.flat;
         end
         if (held_uop.sib_en) begin
            src_req.gpr.flat = src_req.gpr.flat | sib_lanes.flat;
         end
         if (held_uop.seg1_needed) begin
            src_req.seg[held_uop.seg1] = 1'b1;
         end
         if (held_uop.seg2_needed) begin
            src_req.seg[held_uop.seg2] = 1'b1;
         end
      end
   end

endmodule

// File: hw/ag_address_unit.sv
`timescale 1ns/1ps
`include "ag_params.svh"

module ag_address_unit
   import ag_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          full,
   input  uop_t                          held_uop,
   input  logic [`AG_NUM_DS_STAGES-1:0] hit,
   output logic                          release_uop,
   output logic                          out_req,
   input  logic                          out_ack,
   output ag_result_t                    out_res
);

   // Output side states
   localparam logic [1:0] O_IDLE  = 2'd0;
   localparam logic [1:0] O_HOLD  = 2'd1;
   localparam logic [1:0] O_REQ   = 2'd2;
   localparam logic [1:0] O_DRAIN = 2'd3;

   logic [1:0]  ostate;
   logic        stall;
   logic        capture;
   logic [31:0] rel_disp;
   logic [15:0] sib_seg_base;
   logic [31:0] push_adj;
   ag_result_t  res_d;

   assign stall   = |hit;
   assign capture = full && !stall && (ostate == O_IDLE);
   // Latch frees its slot on the same edge the result is taken
   assign release_uop = capture;

   assign rel_disp     = held_uop.jmp_rel ? held_uop.disp32 : 32'd0;
   assign sib_seg_base = held_uop.use_cs_seg ? held_uop.cs : held_uop.seg1_data;

   // Stack step by memory size where byte pushes move by a word
   always_comb begin
      case (held_uop.mem_size)
         2'd3:    push_adj = 32'hffff_fff8;
         2'd2:    push_adj = 32'hffff_fffc;
         default: push_adj = 32'hffff_fffe;
      endcase
   end

   always_comb begin
      res_d = '0;

      // Next EIP and CS
      if (held_uop.far_eip) begin
         res_d.neip = held_uop.far_off[31:0];
      end else begin
         res_d.neip = held_uop.eip + rel_disp;
      end
      res_d.ncs = held_uop.far_cs ? held_uop.far_off[47:32] : held_uop.cs;

      // ALU operands
      case (held_uop.mux_a)
         2'd0:    res_d.a_val = held_uop.sr1_data;
         2'd1:    res_d.a_val = {16'd0, held_uop.seg1_data};
         2'd2:    res_d.a_val = {16'd0, held_uop.seg2_data};
         default: res_d.a_val = {16'd0, held_uop.cs};
      endcase
      res_d.b_val = held_uop.b_imm ? held_uop.imm32 : held_uop.sr2_data;

      // Effective address pieces
      res_d.base_disp = (held_uop.base_en ? held_uop.sr1_data : 32'd0)
                      + (held_uop.disp_en ? held_uop.disp32 : 32'd0);
      if (held_uop.sib_en) begin
         res_d.sib_si = held_uop.sib_i_data << held_uop.sib_scale;
      end
      res_d.sib_seg = {sib_seg_base, 16'd0} + res_d.sib_si;

      // Stack pointer update or exchange value
      if (held_uop.cmpxchg) begin
         res_d.sp_xchg = held_uop.sr3_data;
      end else if (held_uop.sp_push) begin
         res_d.sp_xchg = held_uop.sr2_data + push_adj;
      end else begin
         res_d.sp_xchg = held_uop.sr2_data;
      end

      // NMI wins over page fault and page fault over general protection
      if (held_uop.nmi) begin
         res_d.int_addr = `AG_VEC_NMI;
      end else if (held_uop.pf) begin
         res_d.int_addr = `AG_VEC_PAGE_FAULT;
      end else if (held_uop.gp) begin
         res_d.int_addr = `AG_VEC_GEN_PROT;
      end

      // Own write scoreboard for the stages behind
      res_d.wr_sb.valid = 1'b1;
      if (held_uop.ld_gpr1) begin
         res_d.wr_sb.gpr = gpr_lanes(held_uop.dr1, held_uop.dr1_size);
      end
      if (held_uop.ld_seg) begin
         res_d.wr_sb.seg[held_uop.seg1] = 1'b1;
      end
      if (held_uop.far_cs) begin
         res_d.wr_sb.seg[`AG_SEG_CS] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         out_res <= res_d;
      end
   end

   // Four-phase source handshake on the result register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ostate <= O_IDLE;
      end else begin
         case (ostate)
            O_IDLE: begin
               if (capture) ostate <= O_HOLD;
            end
            O_HOLD:  ostate <= O_REQ;
            O_REQ: begin
               if (out_ack) ostate <= O_DRAIN;
            end
            O_DRAIN: begin
               if (!out_ack) ostate <= O_IDLE;
            end
         endcase
      end
   end

   assign out_req = (ostate == O_REQ);

endmodule

// File: hw/ag_stage.sv
`timescale 1ns/1ps
`include "ag_params.svh"

module ag_stage
   import ag_pkg::*;
(
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               in_req,
   input  uop_t                               in_uop,
   output logic                               in_ack,
   input  sb_t [`AG_NUM_DS_STAGES-1:0]       ds_sb,
   output logic                               out_req,
   input  logic                               out_ack,
   output ag_result_t                         out_res
);

   logic                          full;
   uop_t                          held_uop;
   logic                          release_uop;
   src_req_t                      src_req;
   logic [`AG_NUM_DS_STAGES-1:0] hit;

   ag_operand_latch u_latch (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_req      (in_req),
      .in_uop      (in_uop),
      .in_ack      (in_ack),
      .release_uop (release_uop),
      .full        (full),
      .held_uop    (held_uop),
      .src_req     (src_req)
   );

   // One comparator per downstream stage, index 0 is AG2
   for (genvar g = 0; g < `AG_NUM_DS_STAGES; g++) begin : g_cmp
      hazard_compare u_cmp (
         .src      (src_req),
         .stage_sb (ds_sb[g]),
         .hit      (hit[g])
      );
   end

   ag_address_unit u_addr (
      .clk         (clk),
      .rst_n       (rst_n),
      .full        (full),
      .held_uop    (held_uop),
      .hit         (hit),
      .release_uop (release_uop),
      .out_req     (out_req),
      .out_ack     (out_ack),
      .out_res     (out_res)
   );

endmodule

// File: sim/tb_ag_stage.sv
`timescale 1ns/1ps
`include "ag_params.svh"

module tb_ag_stage
   import ag_pkg::*;
();

   // Rough cycle budget of each test
   localparam int T1_CYCLES = 150;
   localparam int T2_CYCLES = 2000;
   localparam int T3_CYCLES = 150;
   localparam int T4_CYCLES = 250;
   localparam int T5_CYCLES = 100;
   localparam int T6_CYCLES = 350;
   localparam int WATCHDOG_CYCLES =
      (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES + T6_CYCLES) * 20 + 1000;

   logic                         clk = 1'b0;
   logic                         rst_n;
   logic                         in_req;
   uop_t                         in_uop;
   logic                         in_ack;
   sb_t [`AG_NUM_DS_STAGES-1:0] ds_sb;
   logic                         out_req;
   logic                         out_ack;
   ag_result_t                   out_res;

   ag_result_t exp_q[$];
   ag_result_t exp_head = '0;
   int         errors = 0;
   int         tests_run = 0;
   int         out_count = 0;
   int         cycle = 0;
   int         start_cycle = 0;
   int         last_out_cycle = 0;
   bit         hold_out = 1'b0;

   ag_stage u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_req  (in_req),
      .in_uop  (in_uop),
      .in_ack  (in_ack),
      .ds_sb   (ds_sb),
      .out_req (out_req),
      .out_ack (out_ack),
      .out_res (out_res)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   task automatic value_error(input string msg);
      $display("FAILED %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic order_error(input string msg);
      $display("Handshake error at %0t ns: %s", $time, msg);
      errors++;
   endtask

   // Lanes of one register access at bit 3*id + lane
   function automatic logic [23:0] lane_mask(input logic [2:0] id, input logic [1:0] size);
      logic [23:0] m;
      if (size == 2'd0 && id < 3'd4) begin
         m = 24'b001 << (3 * int'(id));
      end else if (size == 2'd0) begin
         // AH, CH, DH, BH live in the high-byte lane of registers 0 to 3
         m = 24'b010 << (3 * (int'(id) - 4));
      end else if (size == 2'd1) begin
         m = 24'b011 << (3 * int'(id));
      end else begin
         m = 24'b111 << (3 * int'(id));
      end
      return m;
   endfunction

   function automatic ag_result_t ref_result(input uop_t u);
      ag_result_t  r;
      logic [31:0] step;
      logic [15:0] seg;
      r = '0;
      if (u.far_eip)
         r.neip = u.far_off[31:0];
      else if (u.jmp_rel)
         r.neip = u.eip + u.disp32;
      else
         r.neip = u.eip;
      r.ncs = u.far_cs ? u.far_off[47:32] : u.cs;
      case (u.mux_a)
         2'd0:    r.a_val = u.sr1_data;
         2'd1:    r.a_val = 32'(u.seg1_data);
         2'd2:    r.a_val = 32'(u.seg2_data);
         default: r.a_val = 32'(u.cs);
      endcase
      r.b_val = u.b_imm ? u.imm32 : u.sr2_data;
      r.base_disp = (u.base_en ? u.sr1_data : 32'd0) + (u.disp_en ? u.disp32 : 32'd0);
      r.sib_si = u.sib_en ? u.sib_i_data * (32'd1 << u.sib_scale) : 32'd0;
      seg = u.use_cs_seg ? u.cs : u.seg1_data;
      r.sib_seg = 32'(seg) * 32'd65536 + r.sib_si;
      case (u.mem_size)
         2'd3:    step = 32'd8;
         2'd2:    step = 32'd4;
         default: step = 32'd2;
      endcase
      if (u.cmpxchg)
         r.sp_xchg = u.sr3_data;
      else if (u.sp_push)
         r.sp_xchg = u.sr2_data - step;
      else
         r.sp_xchg = u.sr2_data;
      if (u.nmi)
         r.int_addr = `AG_VEC_NMI;
      else if (u.pf)
         r.int_addr = `AG_VEC_PAGE_FAULT;
      else if (u.gp)
         r.int_addr = `AG_VEC_GEN_PROT;
      r.wr_sb.valid = 1'b1;
      if (u.ld_gpr1)
         r.wr_sb.gpr.flat = lane_mask(u.dr1, u.dr1_size);
      if (u.ld_seg)
         r.wr_sb.seg = r.wr_sb.seg | (8'b1 << u.seg1);
      if (u.far_cs)
         r.wr_sb.seg = r.wr_sb.seg | (8'b1 << `AG_SEG_CS);
      return r;
   endfunction

   function automatic uop_t random_uop();
      logic [383:0] raw;
      raw = '0;
      for (int i = 0; i < 12; i++) begin
         raw = {raw[351:0], $urandom()};
      end
      return uop_t'(raw[$bits(uop_t)-1:0]);
   endfunction

   task automatic refresh_head();
      if (exp_q.size() > 0)
         exp_head = exp_q[0];
      else
         exp_head = '0;
   endtask

   task automatic wait_in_ack(input logic level);
      int n;
      n = 0;
      while (in_ack !== level && n < 100) begin
         @(negedge clk);
         n++;
      end
      if (in_ack !== level) begin
         $display("Input handshake stuck, in_ack never went to %0b", level);
         errors++;
      end
   endtask

   task automatic start_uop(input uop_t u);
      @(negedge clk);
      in_uop = u;
      in_req = 1'b1;
      exp_q.push_back(ref_result(u));
      refresh_head();
      start_cycle = cycle;
   endtask

   task automatic finish_uop();
      wait_in_ack(1'b1);
      in_req = 1'b0;
      wait_in_ack(1'b0);
   endtask

   task automatic send_uop(input uop_t u);
      start_uop(u);
      finish_uop();
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || out_req || out_ack) && n < 200) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("Output handshake stuck with %0d results outstanding", exp_q.size());
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - err_before);
   endtask

   // Output side consumer that acks every request unless held
   initial begin
      out_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (rst_n && out_req && !out_ack && !hold_out) begin
            assert (exp_q.size() > 0) else order_error("out_req with no micro-op pending");
            out_ack = 1'b1;
            out_count++;
            last_out_cycle = cycle;
         end else if (rst_n && !out_req && out_ack) begin
            out_ack = 1'b0;
            if (exp_q.size() > 0)
               exp_q.delete(0);
            refresh_head();
         end
      end
   end

   check_result: assert property (@(posedge clk) disable iff (!rst_n)
      out_req |-> out_res == exp_head)
      else value_error($sformatf("out_res %h expected %h", out_res, exp_head));

   in_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(in_ack) |-> $past(in_req))
      else order_error("in_ack rose without in_req");

   in_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(in_ack) |-> !$past(in_req))
      else order_error("in_ack fell while in_req was still high");

   out_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(out_req) |-> !$past(out_ack))
      else order_error("out_req rose while out_ack was high");

   out_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(out_req) |-> $past(out_ack))
      else order_error("out_req dropped before out_ack");

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
      $display("Verification failed");
      $finish;
   end

   initial begin
      uop_t u;
      sb_t  stage;
      int   err_before;
      int   count_before;
      void'($urandom(47));
      rst_n  = 1'b0;
      in_req = 1'b0;
      in_uop = '0;
      ds_sb  = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Reset state, ordering and back-pressure
      err_before = errors;
      assert (!in_ack && !out_req) else order_error("in_ack or out_req high after reset");
      count_before = out_count;
      for (int i = 0; i < 6; i++) begin
         send_uop(random_uop());
      end
      wait_drain();
      hold_out = 1'b1;
      send_uop(random_uop());
      send_uop(random_uop());
      start_uop(random_uop());
      repeat (20) begin
         @(negedge clk);
         assert (!in_ack) else order_error("in_ack rose while the output was held");
      end
      hold_out = 1'b0;
      finish_uop();
      wait_drain();
      assert (out_count - count_before == 9)
         else value_error($sformatf("%0d output pulses for 9 micro-ops", out_count - count_before));
      report_test("handshake", err_before);

      err_before = errors;
      for (int i = 0; i < 200; i++) begin
         send_uop(random_uop());
      end
      wait_drain();
      report_test("address arithmetic", err_before);

      // Relative, far and plain control flow, then stack cases
      err_before = errors;
      for (int c = 0; c < 3; c++) begin
         u = random_uop();
         u.jmp_rel = (c == 0);
         u.far_eip = (c == 1);
         u.far_cs  = (c == 1);
         send_uop(u);
      end
      for (int m = 0; m < 4; m++) begin
         u = random_uop();
         u.cmpxchg  = 1'b0;
         u.sp_push  = 1'b1;
         u.mem_size = 2'(m);
         send_uop(u);
      end
      u = random_uop();
      u.cmpxchg = 1'b1;
      u.sp_push = 1'b1;
      send_uop(u);
      wait_drain();
      report_test("control flow and stack", err_before);

      err_before = errors;
      for (int k = 0; k < `AG_NUM_DS_STAGES; k++) begin
         u = random_uop();
         u.sr1_needed = 1'b1;
         stage = '0;
         stage.valid = 1'b1;
         if (k % 2 == 0) begin
            stage.gpr.flat = lane_mask(u.sr1, u.sr1_size);
         end else begin
            u.seg1_needed = 1'b1;
            stage.seg = 8'b1 << u.seg1;
         end
         ds_sb = '0;
         ds_sb[2'(k)] = stage;
         send_uop(u);
         repeat (10) begin
            @(negedge clk);
            assert (!out_req) else order_error("out_req rose with a hazard pending");
         end
         ds_sb[2'(k)].valid = 1'b0;
         wait_drain();
      end
      // AH read behind an AL write
      u = random_uop();
      u.sr1_needed  = 1'b1;
      u.base_en     = 1'b0;
      u.sr2_needed  = 1'b0;
      u.cmpxchg     = 1'b0;
      u.sib_en      = 1'b0;
      u.seg1_needed = 1'b0;
      u.seg2_needed = 1'b0;
      u.sr1         = 3'd4;
      u.sr1_size    = 2'd0;
      stage = '0;
      stage.valid = 1'b1;
      stage.gpr.flat = lane_mask(3'd0, 2'd0);
      ds_sb = '0;
      ds_sb[2'd0] = stage;
      send_uop(u);
      wait_drain();
      assert (last_out_cycle - start_cycle == 3)
         else value_error($sformatf("AH read took %0d cycles", last_out_cycle - start_cycle));
      // Invalid stages with every bit set
      for (int k = 0; k < `AG_NUM_DS_STAGES; k++) begin
         ds_sb[2'(k)] = '1;
         ds_sb[2'(k)].valid = 1'b0;
      end
      u = random_uop();
      u.sr1_needed = 1'b1;
      send_uop(u);
      wait_drain();
      assert (last_out_cycle - start_cycle == 3)
         else value_error($sformatf("invalid stage stalled, %0d cycles",
                                    last_out_cycle - start_cycle));
      ds_sb = '0;
      report_test("hazards", err_before);

      err_before = errors;
      for (int c = 0; c < 8; c++) begin
         u = random_uop();
         {u.nmi, u.pf, u.gp} = 3'(c);
         send_uop(u);
      end
      wait_drain();
      report_test("interrupt priority", err_before);

      err_before = errors;
      for (int d = 0; d < 8; d++) begin
         for (int s = 0; s < 3; s++) begin
            u = random_uop();
            u.ld_gpr1  = 1'b1;
            u.dr1      = 3'(d);
            u.dr1_size = 2'(s);
            send_uop(u);
         end
      end
      for (int d = 0; d < 8; d++) begin
         u = random_uop();
         u.ld_seg = 1'b1;
         u.seg1   = 3'(d);
         u.far_cs = (d == 0);
         send_uop(u);
      end
      wait_drain();
      report_test("write scoreboard", err_before);

      $display("Summary: %0d tests, %0d results checked, %0d errors",
               tests_run, out_count, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: src.f
+incdir+include
hw/ag_pkg.sv
hw/hazard_compare.sv
hw/ag_operand_latch.sv
hw/ag_address_unit.sv
hw/ag_stage.sv
sim/tb_ag_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_ag_stage -o tb_ag_stage

result=$(./obj_dir/tb_ag_stage)
echo "$result"

# Exit status follows the search for the pass line
echo "$result" | grep -qx "Verification passed"
